// ==== src/gpu_ctrl_defines.svh ====
// ------------------------------------------------
// widths and limits shared by the GPU controller
// data and address are both one 32-bit host word
// byte counts must be nonzero multiples of the word
// size, otherwise the copy address never lands on
// the end address
// ------------------------------------------------
`ifndef GPU_CTRL_DEFINES_SVH
`define GPU_CTRL_DEFINES_SVH

// host and memory word width
`define GPU_DATA_W 32
// byte address width
`define GPU_ADDR_W 32
// byte step between consecutive words
`define GPU_WORD_BYTES 4
// most parameter words any opcode takes
`define GPU_MAX_PARAMS 2

`endif

// ==== src/gpu_ctrl_pkg.sv ====
// ------------------------------------------------
// shared types for the GPU host command controller
// opcodes are one full data word wide; any value
// not listed here is decoded as a no-op
// ------------------------------------------------
`include "gpu_ctrl_defines.svh"

package gpu_ctrl_pkg;

    // one host or memory data word
    typedef logic [`GPU_DATA_W-1:0] word_t;

    // byte address into GPU memory
    typedef logic [`GPU_ADDR_W-1:0] addr_t;

    // host opcodes on cpu_recv_instr
    typedef enum logic [`GPU_DATA_W-1:0] {
        OPC_NOP           = 0,
        OPC_COPY_TO_GPU   = 1,
        OPC_COPY_FROM_GPU = 2,
        OPC_KERNEL_LAUNCH = 3
    } opcode_e;

endpackage

// ==== src/cmd_frontend.sv ====
// ------------------------------------------------
// host opcode decode and parameter capture
// opcode sampled only in idle; copies take address
// then byte count, a launch takes the kernel address
// NOP and unknown opcodes leave the front end idle
// waits for the engine done strobe before idling
// ------------------------------------------------
`include "gpu_ctrl_defines.svh"

module cmd_frontend (
    input  logic                clk,
    input  logic                rst,
    input  gpu_ctrl_pkg::word_t cpu_recv_instr,
    input  gpu_ctrl_pkg::word_t cpu_in_data,
    input  logic                xfer_done,
    input  logic                launch_done,
    output logic                xfer_wr_start,
    output logic                xfer_rd_start,
    output logic                launch_start,
    output gpu_ctrl_pkg::addr_t cmd_addr,
    output gpu_ctrl_pkg::addr_t cmd_count
);

    // wide enough to hold the full parameter count
    localparam int PCNT_W = $clog2(`GPU_MAX_PARAMS + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PARAM,
        ST_BUSY
    } state_e;

    state_e                state;
    gpu_ctrl_pkg::opcode_e opcode;
    logic [PCNT_W-1:0]     param_cnt;
    logic                  last_param;
    logic                  engine_done;

    // parameter words per opcode, zero means no-op
    function automatic logic [PCNT_W-1:0] param_count(gpu_ctrl_pkg::opcode_e op);
        case (op)
            gpu_ctrl_pkg::OPC_COPY_TO_GPU,
            gpu_ctrl_pkg::OPC_COPY_FROM_GPU: param_count = PCNT_W'(`GPU_MAX_PARAMS);
            gpu_ctrl_pkg::OPC_KERNEL_LAUNCH: param_count = PCNT_W'(1);
            default:                         param_count = '0;
        endcase
    endfunction

    assign last_param = (param_cnt + PCNT_W'(1)) == param_count(opcode);

    // done strobe from whichever engine owns the opcode
    assign engine_done = (opcode == gpu_ctrl_pkg::OPC_KERNEL_LAUNCH) ? launch_done : xfer_done;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state         <= ST_IDLE;
            opcode        <= gpu_ctrl_pkg::OPC_NOP;
            param_cnt     <= '0;
            xfer_wr_start <= 1'b0;
            xfer_rd_start <= 1'b0;
            launch_start  <= 1'b0;
        end else begin
            // start strobes are single cycle
            xfer_wr_start <= 1'b0;
            xfer_rd_start <= 1'b0;
            launch_start  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    param_cnt <= '0;
                    opcode    <= gpu_ctrl_pkg::opcode_e'(cpu_recv_instr);
                    // nop or unknown, stay here
                    if (param_count(gpu_ctrl_pkg::opcode_e'(cpu_recv_instr)) != '0) begin
                        state <= ST_PARAM;
                    end
                end
                ST_PARAM: begin
                    param_cnt <= param_cnt + PCNT_W'(1);
                    if (last_param) begin
                        state <= ST_BUSY;
                        case (opcode)
                            gpu_ctrl_pkg::OPC_COPY_TO_GPU:   xfer_wr_start <= 1'b1;
                            gpu_ctrl_pkg::OPC_COPY_FROM_GPU: xfer_rd_start <= 1'b1;
                            gpu_ctrl_pkg::OPC_KERNEL_LAUNCH: launch_start  <= 1'b1;
                            default:                         state         <= ST_IDLE;
                        endcase
                    end
                end
                ST_BUSY: begin
                    // host instructions ignored until the engine finishes
                    if (engine_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // first word is the address, second the byte count
    always_ff @(posedge clk) begin
        if (state == ST_PARAM) begin
            if (param_cnt == '0) begin
                cmd_addr <= cpu_in_data;
            end else begin
                cmd_count <= cpu_in_data;
            end
        end
    end

endmodule

// ==== src/mem_xfer_engine.sv ====
// ------------------------------------------------
// word copies between host and GPU memory
// byte count must be a nonzero multiple of the word
// size; the end address is exclusive and compared
// for equality
// reads are issued one at a time, next request goes
// out together with the host ack of the previous one
// ------------------------------------------------
`include "gpu_ctrl_defines.svh"

module mem_xfer_engine (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_start,
    input  logic                rd_start,
    input  gpu_ctrl_pkg::addr_t start_addr,
    input  gpu_ctrl_pkg::addr_t byte_count,
    input  gpu_ctrl_pkg::word_t cpu_in_data,
    input  gpu_ctrl_pkg::word_t mem_rd_data,
    input  logic                mem_rd_ack,
    output logic                mem_wr_en,
    output gpu_ctrl_pkg::addr_t mem_wr_addr,
    output gpu_ctrl_pkg::word_t mem_wr_data,
    output logic                mem_rd_en,
    output gpu_ctrl_pkg::addr_t mem_rd_addr,
    output gpu_ctrl_pkg::word_t xfer_data,
    output logic                xfer_ack,
    output logic                done
);

    localparam gpu_ctrl_pkg::addr_t WORD_STEP = `GPU_WORD_BYTES;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ
    } state_e;

    state_e              state;
    // address of the next word to move
    gpu_ctrl_pkg::addr_t next_addr;
    // one past the last byte of the copy
    gpu_ctrl_pkg::addr_t end_addr;
    gpu_ctrl_pkg::addr_t step_addr;

    assign step_addr = next_addr + WORD_STEP;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= ST_IDLE;
            mem_wr_en <= 1'b0;
            mem_rd_en <= 1'b0;
            xfer_ack  <= 1'b0;
            xfer_data <= '0;
            done      <= 1'b0;
        end else begin
            mem_wr_en <= 1'b0;
            mem_rd_en <= 1'b0;
            xfer_ack  <= 1'b0;
            xfer_data <= '0;
            done      <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (wr_start) begin
                        // start cycle already carries the first word
                        mem_wr_en <= 1'b1;
                        if (byte_count == WORD_STEP) begin
                            done <= 1'b1;
                        end else begin
                            state <= ST_WRITE;
                        end
                    end else if (rd_start) begin
                        mem_rd_en <= 1'b1;
                        state     <= ST_READ;
                    end
                end
                ST_WRITE: begin
                    mem_wr_en <= 1'b1;
                    if (step_addr == end_addr) begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    // a read is always outstanding in this state
                    if (mem_rd_ack) begin
                        xfer_ack  <= 1'b1;
                        xfer_data <= mem_rd_data;
                        if (next_addr == end_addr) begin
                            done  <= 1'b1;
                            state <= ST_IDLE;
                        end else begin
                            mem_rd_en <= 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // addresses and write data
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (wr_start || rd_start) begin
                    next_addr <= start_addr + WORD_STEP;
                    end_addr  <= start_addr + byte_count;
                end
                mem_wr_addr <= start_addr;
                mem_wr_data <= cpu_in_data;
                mem_rd_addr <= start_addr;
            end
            ST_WRITE: begin
                mem_wr_addr <= next_addr;
                mem_wr_data <= cpu_in_data;
                next_addr   <= step_addr;
            end
            ST_READ: begin
                if (mem_rd_ack && next_addr != end_addr) begin
                    mem_rd_addr <= next_addr;
                    next_addr   <= step_addr;
                end
            end
            default: begin
                next_addr <= next_addr;
            end
        endcase
    end

endmodule

// ==== src/kernel_launcher.sv ====
// ------------------------------------------------
// kernel launch sequencer for a single core
// program counter set for one cycle, then the core
// runs until halt; no timeout, a core that never
// halts keeps the controller busy
// ------------------------------------------------
module kernel_launcher (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  gpu_ctrl_pkg::addr_t kernel_addr,
    input  logic                core_halt,
    output logic                core_set_pc_req,
    output gpu_ctrl_pkg::addr_t core_set_pc_addr,
    output logic                core_ena,
    output logic                core_clr,
    output logic                launch_ack,
    output logic                done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SET_PC,
        ST_RUN
    } state_e;

    state_e state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state           <= ST_IDLE;
            core_set_pc_req <= 1'b0;
            core_ena        <= 1'b0;
            core_clr        <= 1'b0;
            launch_ack      <= 1'b0;
            done            <= 1'b0;
        end else begin
            core_set_pc_req <= 1'b0;
            core_clr        <= 1'b0;
            launch_ack      <= 1'b0;
            done            <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        core_set_pc_req <= 1'b1;
                        state           <= ST_SET_PC;
                    end
                end
                ST_SET_PC: begin
                    // pc loaded, let the core run
                    core_ena <= 1'b1;
                    state    <= ST_RUN;
                end
                ST_RUN: begin
                    // clear and ack land together one cycle after halt
                    if (core_halt) begin
                        core_ena   <= 1'b0;
                        core_clr   <= 1'b1;
                        launch_ack <= 1'b1;
                        done       <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // pc address only matters while the request is high
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            core_set_pc_addr <= kernel_addr;
        end
    end

endmodule

// ==== src/gpu_controller.sv ====
// ------------------------------------------------
// GPU host command controller, top level
// one command runs at a time; opcodes presented
// while a command is busy are ignored
// host gets no back-pressure; memory stalls only
// through read latency, one read outstanding
// ------------------------------------------------
module gpu_controller (
    input  logic                clk,
    input  logic                rst,

    // host side
    input  gpu_ctrl_pkg::word_t cpu_recv_instr,
    input  gpu_ctrl_pkg::word_t cpu_in_data,
    output gpu_ctrl_pkg::word_t cpu_out_data,
    output logic                cpu_out_ack,

    // memory side
    output logic                mem_wr_en,
    output gpu_ctrl_pkg::addr_t mem_wr_addr,
    output gpu_ctrl_pkg::word_t mem_wr_data,
    output logic                mem_rd_en,
    output gpu_ctrl_pkg::addr_t mem_rd_addr,
    input  gpu_ctrl_pkg::word_t mem_rd_data,
    input  logic                mem_rd_ack,

    // core side
    output logic                core_ena,
    output logic                core_clr,
    output logic                core_set_pc_req,
    output gpu_ctrl_pkg::addr_t core_set_pc_addr,
    input  logic                core_halt
);

    // front end to engines
    logic                xfer_wr_start;
    logic                xfer_rd_start;
    logic                launch_start;
    gpu_ctrl_pkg::addr_t cmd_addr;
    gpu_ctrl_pkg::addr_t cmd_count;

    // engines back to front end and host
    logic                xfer_done;
    logic                launch_done;
    gpu_ctrl_pkg::word_t xfer_data;
    logic                xfer_ack;
    logic                launch_ack;

    cmd_frontend u_cmd_frontend (
        .clk            (clk),
        .rst            (rst),
        .cpu_recv_instr (cpu_recv_instr),
        .cpu_in_data    (cpu_in_data),
        .xfer_done      (xfer_done),
        .launch_done    (launch_done),
        .xfer_wr_start  (xfer_wr_start),
        .xfer_rd_start  (xfer_rd_start),
        .launch_start   (launch_start),
        .cmd_addr       (cmd_addr),
        .cmd_count      (cmd_count)
    );

    mem_xfer_engine u_mem_xfer_engine (
        .clk         (clk),
        .rst         (rst),
        .wr_start    (xfer_wr_start),
        .rd_start    (xfer_rd_start),
        .start_addr  (cmd_addr),
        .byte_count  (cmd_count),
        .cpu_in_data (cpu_in_data),
        .mem_rd_data (mem_rd_data),
        .mem_rd_ack  (mem_rd_ack),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .xfer_data   (xfer_data),
        .xfer_ack    (xfer_ack),
        .done        (xfer_done)
    );

    kernel_launcher u_kernel_launcher (
        .clk              (clk),
        .rst              (rst),
        .start            (launch_start),
        .kernel_addr      (cmd_addr),
        .core_halt        (core_halt),
        .core_set_pc_req  (core_set_pc_req),
        .core_set_pc_addr (core_set_pc_addr),
        .core_ena         (core_ena),
        .core_clr         (core_clr),
        .launch_ack       (launch_ack),
        .done             (launch_done)
    );

    // only one engine active at a time, so a plain OR is enough
    assign cpu_out_ack  = xfer_ack | launch_ack;
    // engine holds data at zero outside its ack, so launch ack reads zero
    assign cpu_out_data = xfer_data;

endmodule

// ==== bench/gpu_controller_checker.sv ====
// ------------------------------------------------
// protocol assertions for the GPU controller
// bound into gpu_controller, checked on the rising
// clock edge, and quiet while reset is low
// failures are counted so the testbench can read
// the total at the end of the run
// ------------------------------------------------
module gpu_controller_checker (
    input logic clk,
    input logic rst,
    input logic mem_wr_en,
    input logic mem_rd_en,
    input logic core_set_pc_req,
    input logic core_clr,
    input logic cpu_out_ack,
    input logic core_ena
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // one memory direction per cycle
    wr_rd_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(mem_wr_en && mem_rd_en))
        else begin
            $error("memory write and read requested in the same cycle");
            fail_count++;
        end

    // pc request is a single cycle pulse
    set_pc_single: assert property (@(posedge clk) disable iff (!rst)
        core_set_pc_req |=> !core_set_pc_req)
        else begin
            $error("core_set_pc_req held for more than one cycle");
            fail_count++;
        end

    // clear always comes with the host ack
    clr_with_ack: assert property (@(posedge clk) disable iff (!rst)
        core_clr |-> cpu_out_ack)
        else begin
            $error("core_clr without cpu_out_ack");
            fail_count++;
        end

    // memory stays quiet while a kernel runs
    no_mem_while_run: assert property (@(posedge clk) disable iff (!rst)
        core_ena |-> !(mem_wr_en || mem_rd_en))
        else begin
            $error("memory access while core_ena is high");
            fail_count++;
        end

endmodule

bind gpu_controller gpu_controller_checker u_gpu_controller_checker (
    .clk             (clk),
    .rst             (rst),
    .mem_wr_en       (mem_wr_en),
    .mem_rd_en       (mem_rd_en),
    .core_set_pc_req (core_set_pc_req),
    .core_clr        (core_clr),
    .cpu_out_ack     (cpu_out_ack),
    .core_ena        (core_ena)
);

// ==== bench/gpu_controller_tb.sv ====
// ------------------------------------------------
// testbench for the GPU host command controller
// reads bench/gpu_ctrl_stimulus.txt, so run it from
// the project root
// memory model covers byte addresses 0 to 0x3ff
// stops at the first mismatch
// ------------------------------------------------
`include "gpu_ctrl_defines.svh"

module gpu_controller_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam gpu_ctrl_pkg::word_t END_MARK = 32'hffff_ffff;

    logic                clk;
    logic                rst;
    gpu_ctrl_pkg::word_t cpu_recv_instr;
    gpu_ctrl_pkg::word_t cpu_in_data;
    gpu_ctrl_pkg::word_t cpu_out_data;
    logic                cpu_out_ack;
    logic                mem_wr_en;
    gpu_ctrl_pkg::addr_t mem_wr_addr;
    gpu_ctrl_pkg::word_t mem_wr_data;
    logic                mem_rd_en;
    gpu_ctrl_pkg::addr_t mem_rd_addr;
    gpu_ctrl_pkg::word_t mem_rd_data;
    logic                mem_rd_ack;
    logic                core_ena;
    logic                core_clr;
    logic                core_set_pc_req;
    gpu_ctrl_pkg::addr_t core_set_pc_addr;
    logic                core_halt;

    gpu_ctrl_pkg::word_t stim [0:255];
    gpu_ctrl_pkg::word_t mem [0:255];
    // expected results, filled when a command starts
    gpu_ctrl_pkg::addr_t exp_wr_addr [$];
    gpu_ctrl_pkg::word_t exp_wr_data [$];
    gpu_ctrl_pkg::word_t exp_rd_data [$];
    gpu_ctrl_pkg::addr_t exp_pc [$];
    int                  exp_halt [$];
    logic [31:0]         lcg_state = 32'h0d4a_71d0;
    int                  limit_cycles = 0;
    // read model and core model state
    int                  rd_wait = 0;
    gpu_ctrl_pkg::addr_t rd_addr;
    int                  halt_target = 0;
    int                  ena_cycles = 0;

    gpu_controller u_gpu_controller (
        .clk              (clk),
        .rst              (rst),
        .cpu_recv_instr   (cpu_recv_instr),
        .cpu_in_data      (cpu_in_data),
        .cpu_out_data     (cpu_out_data),
        .cpu_out_ack      (cpu_out_ack),
        .mem_wr_en        (mem_wr_en),
        .mem_wr_addr      (mem_wr_addr),
        .mem_wr_data      (mem_wr_data),
        .mem_rd_en        (mem_rd_en),
        .mem_rd_addr      (mem_rd_addr),
        .mem_rd_data      (mem_rd_data),
        .mem_rd_ack       (mem_rd_ack),
        .core_ena         (core_ena),
        .core_clr         (core_clr),
        .core_set_pc_req  (core_set_pc_req),
        .core_set_pc_addr (core_set_pc_addr),
        .core_halt        (core_halt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // word index into the memory model
    function automatic logic [7:0] mem_index(gpu_ctrl_pkg::addr_t a);
        return a[9:2];
    endfunction

    function automatic gpu_ctrl_pkg::word_t stim_at(int i);
        return stim[i[7:0]];
    endfunction

    // words taken by one command in the stimulus file
    function automatic int cmd_length(int at);
        case (stim_at(at))
            gpu_ctrl_pkg::OPC_COPY_TO_GPU,
            gpu_ctrl_pkg::OPC_COPY_FROM_GPU:
                return 3 + int'(stim_at(at + 2)) / `GPU_WORD_BYTES;
            gpu_ctrl_pkg::OPC_KERNEL_LAUNCH: return 3;
            default:                         return 1;
        endcase
    endfunction

    // 8 cycles per data word, halt cycles, 20 per command
    function automatic int cycle_budget();
        int at;
        int cycles;
        at = 0;
        cycles = 40;
        while (stim_at(at) != END_MARK) begin
            if (stim_at(at) == gpu_ctrl_pkg::OPC_KERNEL_LAUNCH) begin
                cycles += int'(stim_at(at + 2)) + 20;
            end else if (cmd_length(at) > 3) begin
                cycles += 8 * (cmd_length(at) - 3) + 20;
            end else begin
                cycles += 20;
            end
            at += cmd_length(at);
        end
        return cycles;
    endfunction

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input gpu_ctrl_pkg::word_t exp,
                              input gpu_ctrl_pkg::word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input gpu_ctrl_pkg::addr_t exp,
                              input gpu_ctrl_pkg::addr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // inputs change on the falling edge only
    task automatic drive_cycle(input gpu_ctrl_pkg::word_t instr,
                               input gpu_ctrl_pkg::word_t data);
        @(negedge clk);
        cpu_recv_instr = instr;
        cpu_in_data    = data;
    endtask

    task automatic wait_acks(input int count);
        int seen;
        seen = 0;
        while (seen < count) begin
            drive_cycle(gpu_ctrl_pkg::OPC_NOP, '0);
            if (cpu_out_ack) begin
                seen++;
            end
        end
    endtask

    task automatic copy_to_gpu(input int at);
        int words;
        words = cmd_length(at) - 3;
        for (int i = 0; i < words; i++) begin
            exp_wr_addr.push_back(stim_at(at + 1) + gpu_ctrl_pkg::addr_t'(4 * i));
            exp_wr_data.push_back(stim_at(at + 3 + i));
        end
        drive_cycle(gpu_ctrl_pkg::OPC_COPY_TO_GPU, '0);
        drive_cycle(gpu_ctrl_pkg::OPC_NOP, stim_at(at + 1));
        drive_cycle(gpu_ctrl_pkg::OPC_NOP, stim_at(at + 2));
        // data follows the count with no gap
        for (int i = 0; i < words; i++) begin
            drive_cycle(gpu_ctrl_pkg::OPC_NOP, stim_at(at + 3 + i));
        end
        // one idle cycle, then the next opcode is allowed
        drive_cycle(gpu_ctrl_pkg::OPC_NOP, '0);
    endtask

    task automatic copy_from_gpu(input int at);
        int words;
        words = cmd_length(at) - 3;
        for (int i = 0; i < words; i++) begin
            exp_rd_data.push_back(stim_at(at + 3 + i));
        end
        drive_cycle(gpu_ctrl_pkg::OPC_COPY_FROM_GPU, '0);
        drive_cycle(gpu_ctrl_pkg::OPC_NOP, stim_at(at + 1));
        drive_cycle(gpu_ctrl_pkg::OPC_NOP, stim_at(at + 2));
        wait_acks(words);
        // one idle cycle after the last ack
        drive_cycle(gpu_ctrl_pkg::OPC_NOP, '0);
    endtask

    task automatic kernel_launch(input int at);
        exp_pc.push_back(stim_at(at + 1));
        exp_halt.push_back(int'(stim_at(at + 2)));
        drive_cycle(gpu_ctrl_pkg::OPC_KERNEL_LAUNCH, '0);
        drive_cycle(gpu_ctrl_pkg::OPC_NOP, stim_at(at + 1));
        wait_acks(1);
        // one idle cycle after the launch ack
        drive_cycle(gpu_ctrl_pkg::OPC_NOP, '0);
    endtask

    // memory, core and host side models, sampled mid-cycle
    always @(negedge clk) begin
        mem_rd_ack  = 1'b0;
        mem_rd_data = '0;
        if (rst) begin
            if (mem_wr_en) begin
                if (exp_wr_addr.size() == 0) begin
                    $display("memory write to %08h with no copy in progress", mem_wr_addr);
                    stop_run();
                end else begin
                    check_addr("copy to GPU address", exp_wr_addr.pop_front(), mem_wr_addr);
                    check_word("copy to GPU data", exp_wr_data.pop_front(), mem_wr_data);
                    mem[mem_index(mem_wr_addr)] = mem_wr_data;
                end
            end
            // read answer 1 to 4 cycles after the request
            if (rd_wait > 0) begin
                rd_wait--;
                if (rd_wait == 0) begin
                    mem_rd_ack  = 1'b1;
                    mem_rd_data = mem[mem_index(rd_addr)];
                end
            end
            if (mem_rd_en) begin
                if (exp_rd_data.size() == 0) begin
                    $display("memory read of %08h with no copy in progress", mem_rd_addr);
                    stop_run();
                end else begin
                    rd_addr = mem_rd_addr;
                    rd_wait = int'(lcg_next() >> 30) + 1;
                end
            end
            if (core_set_pc_req) begin
                if (exp_pc.size() == 0) begin
                    $display("core program counter set with no launch in progress");
                    stop_run();
                end else begin
                    check_addr("kernel address", exp_pc.pop_front(), core_set_pc_addr);
                    halt_target = exp_halt.pop_front();
                    ena_cycles  = 0;
                end
            end
            if (cpu_out_ack) begin
                if (core_clr) begin
                    check_word("launch ack data", '0, cpu_out_data);
                    check_bit("core enable at clear", 1'b0, core_ena);
                    check_word("core run cycles", gpu_ctrl_pkg::word_t'(halt_target),
                               gpu_ctrl_pkg::word_t'(ena_cycles));
                end else if (exp_rd_data.size() == 0) begin
                    $display("host ack with no read or launch in progress");
                    stop_run();
                end else begin
                    check_word("copy from GPU data", exp_rd_data.pop_front(), cpu_out_data);
                end
            end
            // core halts after its enabled cycle count
            if (core_ena) begin
                ena_cycles++;
                core_halt = (ena_cycles >= halt_target);
            end else begin
                core_halt = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run hung", limit_cycles);
        stop_run();
    end

    initial begin : main
        int at;
        rst            = 1'b0;
        cpu_recv_instr = '0;
        cpu_in_data    = '0;
        mem_rd_data    = '0;
        mem_rd_ack     = 1'b0;
        core_halt      = 1'b0;
        for (int i = 0; i < 256; i++) begin
            stim[i[7:0]] = END_MARK;
            mem[i[7:0]]  = 32'h5a00_0000 | gpu_ctrl_pkg::word_t'(4 * i);
        end
        $readmemh("bench/gpu_ctrl_stimulus.txt", stim);
        limit_cycles = cycle_budget();
        // four rising edges in reset, release on the falling edge
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        // every strobe low before the first opcode
        drive_cycle(gpu_ctrl_pkg::OPC_NOP, '0);
        check_bit("ack after reset", 1'b0, cpu_out_ack);
        check_bit("mem_wr_en after reset", 1'b0, mem_wr_en);
        check_bit("mem_rd_en after reset", 1'b0, mem_rd_en);
        check_bit("core_ena after reset", 1'b0, core_ena);
        check_bit("core_clr after reset", 1'b0, core_clr);
        check_bit("core_set_pc_req after reset", 1'b0, core_set_pc_req);
        at = 0;
        while (stim_at(at) != END_MARK) begin
            case (stim_at(at))
                gpu_ctrl_pkg::OPC_COPY_TO_GPU:   copy_to_gpu(at);
                gpu_ctrl_pkg::OPC_COPY_FROM_GPU: copy_from_gpu(at);
                gpu_ctrl_pkg::OPC_KERNEL_LAUNCH: kernel_launch(at);
                default:                         drive_cycle(stim_at(at), '0);
            endcase
            at += cmd_length(at);
        end
        repeat (4) drive_cycle(gpu_ctrl_pkg::OPC_NOP, '0);
        if (exp_wr_addr.size() == 0 && exp_rd_data.size() == 0 && exp_pc.size() == 0
            && u_gpu_controller.u_gpu_controller_checker.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("commands left unfinished or protocol assertions failed");
            stop_run();
        end
    end

endmodule

// ==== bench/gpu_ctrl_stimulus.txt ====
// hex words: opcode, then 1 = addr count data..., 2 = addr count expected...,
// 3 = addr halt_cycles; any other opcode stands alone, ffffffff ends the list
00000000
00000001 00000000 00000010 11111111 22222222 33333333 44444444
00000002 00000000 00000010 11111111 22222222 33333333 44444444
00000003 00000400 00000005
00000007
00000001 00000040 00000004 cafef00d
00000002 00000040 00000004 cafef00d
0000abcd
00000003 00000200 00000001
00000001 00000080 0000000c a5a50001 a5a50002 a5a50003
00000002 00000004 00000008 22222222 33333333
00000003 00000300 00000003
00000002 00000080 0000000c a5a50001 a5a50002 a5a50003
00000001 000003f0 00000010 0f0f0f0f 1e1e1e1e 2d2d2d2d 3c3c3c3c
00000002 000003f8 00000008 2d2d2d2d 3c3c3c3c
00000003 00000010 00000002
00000000
00000002 00000000 00000004 11111111
ffffffff

// ==== gpu_ctrl.f ====
+incdir+src
src/gpu_ctrl_pkg.sv
src/cmd_frontend.sv
src/mem_xfer_engine.sv
src/kernel_launcher.sv
src/gpu_controller.sv
bench/gpu_controller_checker.sv
bench/gpu_controller_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the GPU controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module gpu_controller_tb -f gpu_ctrl.f \
    || { echo "build failed"; exit 1; }
./obj_dir/Vgpu_controller_tb > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
